// File: src.f
gba_pkg.sv
cart_download_monitor.sv
bios_word_packer.sv
save_size_tracker.sv
backup_sequencer.sv
block_transfer.sv
backup_buffer.sv
gba_backup_top.sv
tb_gba_backup.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the GBA backup testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tb_gba_backup -o sim

out=$(./obj_dir/sim)
echo "$out"

if grep -q "^Simulation PASSED$" <<< "$out"; then
	exit 0
fi
exit 1

// File: tb_gba_backup.sv
// ==============================
// GBA download and backup testbench
// Download stimulus, SD and memory models,
// assertion checks on the top level
// ==============================
`timescale 1ns/1ns

module tb_gba_backup
	import gba_pkg::*;
();

	localparam logic [31:0] IMG_SIZE        = 32'h0000_2000; // 16 blocks of 512 bytes
	localparam int          HW_CYCLES       = 6;            // Worst halfword turnaround
	localparam int          SECTOR_CYCLES   = 256 * HW_CYCLES + 300;
	localparam int          WATCHDOG_CYCLES = (256 + 16) * SECTOR_CYCLES + 20000;

	// DUT inputs
	logic        clk_sys;
	logic        rst_n;
	logic        ioctl_download;
	logic [7:0]  ioctl_index;
	logic [26:0] ioctl_addr;
	logic [15:0] ioctl_dout;
	logic        ioctl_wr;
	logic        save_eeprom, save_sram, save_flash, bus_req;
	logic        img_mounted, img_readonly;
	logic [31:0] img_size;
	logic        bk_load, bk_save;
	logic        sd_ack;
	buf_addr_t   sd_buff_addr;
	logic        sd_buff_wr;
	logic [15:0] sd_buff_dout;
	logic [15:0] mem_dout;
	logic        mem_ready;
	// DUT outputs
	logic        cart_download, flash_1m;
	logic [26:0] last_addr;
	logic [11:0] bios_wraddr;
	logic [31:0] bios_wrdata;
	logic        bios_wr;
	logic        bk_ena, bk_pending, bk_busy, bk_loading;
	logic [31:0] sd_lba;
	logic        sd_rd, sd_wr;
	logic [15:0] sd_buff_din;
	logic [15:0] mem_addr, mem_din;
	logic        mem_req, mem_rnw;

	int          value_errors = 0;
	int          other_errors = 0;
	logic [15:0] lfsr = 16'd14174;
	logic [15:0] mem_model [0:65535];
	logic [15:0] load_data [0:255];   // Sector last sent on a load
	logic [43:0] bios_q [$];          // {word address, high, low} awaiting bios_wr
	logic [43:0] bios_exp;
	int          bios_words = 0;
	int          sd_blocks = 0;       // Sectors served in this operation
	int          load_writes = 0;
	logic        in_save, in_load;

	gba_backup_top #(.BIOS_AW(12), .MAX_LOAD_BLOCKS(256)) dut (.*);

	initial clk_sys = 1'b0;
	always #50 clk_sys = ~clk_sys;

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic logic [15:0] rand_bits(input int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v    = {v[14:0], lfsr[0]}; // One step per bit
		end
		return v;
	endfunction

	// Initial memory image depends on every address bit
	function automatic logic [15:0] fill_word(input logic [15:0] a);
		return (a * 16'd40503) ^ {a[7:0], a[15:8]} ^ 16'h3C5A;
	endfunction

	function automatic void value_error(input string msg);
		value_errors++;
		$display("FAILED at %0t ns: %s", $time, msg);
	endfunction

	function automatic void other_error(input string msg);
		other_errors++;
		$display("Error at %0t ns: %s", $time, msg);
	endfunction

	// ==============================
	// Protocol checks
	// ==============================
	assert property (@(posedge clk_sys) disable iff (!rst_n) !(sd_rd && sd_wr))
		else other_error("sd_rd and sd_wr were raised together");
	assert property (@(posedge clk_sys) disable iff (!rst_n) bios_wr |-> !cart_download)
		else value_error("bios_wr during a cartridge download");
	assert property (@(posedge clk_sys) disable iff (!rst_n)
		(mem_req && in_save) |-> mem_rnw)
		else value_error("mem_rnw low on a save request");
	assert property (@(posedge clk_sys) disable iff (!rst_n)
		(mem_req && in_load) |-> !mem_rnw)
		else value_error("mem_rnw high on a load request");
	assert property (@(posedge clk_sys) disable iff (!rst_n)
		(in_load && bk_busy) |-> bk_loading)
		else value_error("bk_loading low during a load");

	// BIOS word strobes against the pairs sent
	always @(posedge clk_sys) begin
		if (rst_n && bios_wr) begin
			bios_words++;
			if (bios_q.size() == 0) begin
				value_error("bios_wr with no halfword pair sent");
			end else begin
				bios_exp = bios_q.pop_front();
				assert (bios_wrdata == bios_exp[31:0] && bios_wraddr == bios_exp[43:32])
					else value_error($sformatf("BIOS word %h @%h, expected %h @%h",
						bios_wrdata, bios_wraddr, bios_exp[31:0], bios_exp[43:32]));
			end
		end
	end

	// ==============================
	// Memory model
	// ==============================
	initial begin : memory_model
		logic [15:0] addr;
		logic        rnw;
		int          delay;
		mem_ready = 1'b0;
		mem_dout  = '0;
		for (int a = 0; a < 65536; a++)
			mem_model[a] = fill_word(16'(a));
		forever begin
			@(posedge clk_sys);
			mem_ready <= 1'b0;
			if (mem_req) begin
				addr  = mem_addr;
				rnw   = mem_rnw;
				delay = 1 + int'(rand_bits(2)); // 1..4 cycles
				if (!rnw) begin
					mem_model[addr] = mem_din;  // Buffer data held since the request
					load_writes++;
					assert (mem_din == load_data[addr[7:0]] && addr[15:8] == 8'(sd_blocks - 1))
						else value_error($sformatf("load write %h @%h, expected %h",
							mem_din, addr, load_data[addr[7:0]]));
				end
				repeat (delay - 1) @(posedge clk_sys);
				mem_ready <= 1'b1;
				if (rnw) mem_dout <= mem_model[addr];
			end
		end
	end

	// ==============================
	// SD model
	// ==============================
	initial begin : sd_model
		logic        rd;
		logic [15:0] d;
		logic [15:0] cap [0:255];
		int          bad;
		sd_ack       = 1'b0;
		sd_buff_addr = '0;
		sd_buff_wr   = 1'b0;
		sd_buff_dout = '0;
		forever begin
			@(posedge clk_sys);
			if (rst_n && (sd_rd || sd_wr)) begin
				rd = sd_rd;
				assert (sd_lba == 32'(sd_blocks) && rd == in_load)
					else value_error($sformatf("SD request lba %0d rd %b, expected %0d rd %b",
						sd_lba, rd, sd_blocks, in_load));
				if (rd) begin
					assert (load_writes == sd_blocks * 256)
						else value_error($sformatf("%0d memory writes before sector %0d",
							load_writes, sd_blocks));
				end
				repeat (1 + int'(rand_bits(2))) @(posedge clk_sys);
				sd_ack <= 1'b1;
				for (int i = 0; i < 258; i++) begin
					if (rd && i < 256) begin
						d            = rand_bits(16);
						load_data[i] = d;
						sd_buff_addr <= buf_addr_t'(i);
						sd_buff_dout <= d;
						sd_buff_wr   <= 1'b1;
					end else if (rd) begin
						sd_buff_wr <= 1'b0;
					end else begin
						if (i >= 2) cap[i-2] = sd_buff_din; // Two edges behind the address
						if (i < 256) sd_buff_addr <= buf_addr_t'(i);
					end
					@(posedge clk_sys);
				end
				sd_ack <= 1'b0;
				if (!rd) begin
					bad = 0;
					for (int i = 0; i < 256; i++)
						if (cap[i] != fill_word({8'(sd_blocks), 8'(i)})) bad++;
					assert (bad == 0)
						else value_error($sformatf("saved sector %0d has %0d wrong halfwords",
							sd_blocks, bad));
				end
				sd_blocks++;
			end
		end
	end

	// ==============================
	// Stimulus tasks
	// ==============================
	task automatic send_bios(input int halfwords, input logic [26:0] base);
		logic [15:0] lo;
		logic [15:0] d;
		logic [26:0] a;
		lo = '0;
		@(posedge clk_sys);
		ioctl_download <= 1'b1;
		ioctl_index    <= 8'd0;
		repeat (2) @(posedge clk_sys);  // Class registered first
		assert (!cart_download) else value_error("cart_download high for a BIOS download");
		for (int i = 0; i < halfwords; i++) begin
			a = base + 27'(2 * i);
			d = rand_bits(16);
			if (a[1]) bios_q.push_back({a[13:2], d, lo});
			else      lo = d;
			ioctl_addr <= a;
			ioctl_dout <= d;
			ioctl_wr   <= 1'b1;
			@(posedge clk_sys);
			ioctl_wr <= 1'b0;
			@(posedge clk_sys);
		end
		ioctl_download <= 1'b0;
		repeat (3) @(posedge clk_sys);
	endtask

	// Order 0 sends no marker, 1 low byte first, 2 high byte first
	// Marker starts at byte pos of the stream
	task automatic cart_case(input logic [7:0] index, input int halfwords, input int order,
		input int pos);
		logic [7:0]  seq [0:511];
		logic [71:0] sig;
		logic [15:0] d;
		sig = "FLASH1M_V";
		for (int i = 0; i < 2 * halfwords; i++)
			seq[i] = 8'(rand_bits(8));
		if (order != 0)
			for (int i = 0; i < 9; i++)
				seq[pos + i] = sig[71 - 8 * i -: 8];
		@(posedge clk_sys);
		ioctl_download <= 1'b1;
		ioctl_index    <= index;
		repeat (2) @(posedge clk_sys);
		assert (cart_download) else value_error("cart_download low during a cartridge stream");
		for (int j = 0; j < halfwords; j++) begin
			if (order == 2) d = {seq[2 * j], seq[2 * j + 1]};
			else            d = {seq[2 * j + 1], seq[2 * j]};
			ioctl_addr <= 27'(2 * j);
			ioctl_dout <= d;
			ioctl_wr   <= 1'b1;
			@(posedge clk_sys);
			ioctl_wr <= 1'b0;
			@(posedge clk_sys);
		end
		ioctl_download <= 1'b0;
		repeat (4) @(posedge clk_sys);  // End edge then address capture
		assert (last_addr == 27'(2 * (halfwords - 1)) && flash_1m == (order != 0) &&
			!cart_download)
			else value_error($sformatf("cart order %0d: last_addr %h flash_1m %b download %b",
				order, last_addr, flash_1m, cart_download));
	endtask

	// Start then completion of one backup operation
	task automatic run_op(input string name);
		int n;
		n = 0;
		while (!bk_busy && n < 10) begin
			@(posedge clk_sys);
			n++;
		end
		if (!bk_busy) other_error({name, " did not start"});
		while (bk_busy) @(posedge clk_sys);
	endtask

	// ==============================
	// Main sequence
	// ==============================
	initial begin
		rst_n          = 1'b0;
		ioctl_download = 1'b0;
		ioctl_index    = '0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		ioctl_wr       = 1'b0;
		save_eeprom    = 1'b0;
		save_sram      = 1'b0;
		save_flash     = 1'b0;
		bus_req        = 1'b0;
		img_mounted    = 1'b0;
		img_readonly   = 1'b0;
		img_size       = '0;
		bk_load        = 1'b0;
		bk_save        = 1'b0;
		in_save        = 1'b0;
		in_load        = 1'b0;
		repeat (16) @(posedge clk_sys);
		rst_n <= 1'b1;
		@(posedge clk_sys);
		assert (!(bios_wr | sd_rd | sd_wr | mem_req | dut.xfer_start | bk_busy |
			bk_loading | bk_pending | bk_ena | flash_1m))
			else value_error("control output not low after reset");

		send_bios(12, 27'h400);
		assert (bios_words == 6 && bios_q.size() == 0)
			else value_error($sformatf("%0d BIOS words for 6 pairs", bios_words));

		// Marker ending on the second byte of a halfword, then on the first
		cart_case(8'd1, 16, 1, 7);
		cart_case(8'd5, 20, 0, 0);
		cart_case(8'd254, 24, 2, 7);
		cart_case(8'd2, 16, 1, 10);
		cart_case(8'd3, 16, 2, 10);

		// Save size from SRAM activity, then from an image
		assert (!bk_ena && !bk_pending) else value_error("save state set before any save");
		@(posedge clk_sys);
		save_sram <= 1'b1;
		bus_req   <= 1'b1;
		@(posedge clk_sys);
		save_sram <= 1'b0;
		bus_req   <= 1'b0;
		repeat (3) @(posedge clk_sys);
		assert (bk_ena && bk_pending) else value_error("bk_ena or bk_pending low after SRAM write");
		img_size    <= IMG_SIZE;
		img_mounted <= 1'b1;
		@(posedge clk_sys);
		img_mounted <= 1'b0;
		repeat (2) @(posedge clk_sys);

		sd_blocks = 0;
		in_save <= 1'b1;
		bk_save <= 1'b1;
		run_op("save");
		bk_save <= 1'b0;
		in_save <= 1'b0;
		assert (sd_blocks == int'(IMG_SIZE[16:9]) && !bk_pending)
			else value_error($sformatf("save wrote %0d sectors, pending %b", sd_blocks, bk_pending));

		sd_blocks   = 0;
		load_writes = 0;
		@(posedge clk_sys);
		in_load <= 1'b1;
		bk_load <= 1'b1;
		run_op("load");
		bk_load <= 1'b0;
		in_load <= 1'b0;
		assert (sd_blocks == 256 && load_writes == 256 * 256)
			else value_error($sformatf("load read %0d sectors, %0d memory writes",
				sd_blocks, load_writes));

		repeat (5) @(posedge clk_sys);
		$display("Errors: %0d value, %0d other", value_errors, other_errors);
		if (value_errors + other_errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		other_error("watchdog expired before the tests finished");
		$display("Errors: %0d value, %0d other", value_errors, other_errors);
		$display("Simulation FAILED");
		$finish;
	end

endmodule

// File: gba_backup_top.sv
// ==============================
// GBA download and backup top level
// Download front end plus save-memory
// transfer between memory and SD
// ==============================
`timescale 1ns/1ns

module gba_backup_top
	import gba_pkg::*;
#(
	parameter int BIOS_AW         = 12,
	parameter int MAX_LOAD_BLOCKS = 256
) (
	input  logic               clk_sys,
	input  logic               rst_n,
	input  logic               ioctl_download,
	input  logic [7:0]         ioctl_index,
	input  logic [26:0]        ioctl_addr,
	input  logic [15:0]        ioctl_dout,
	input  logic               ioctl_wr,
	input  logic               save_eeprom,
	input  logic               save_sram,
	input  logic               save_flash,
	input  logic               bus_req,
	input  logic               img_mounted,
	input  logic               img_readonly,
	input  logic [31:0]        img_size,
	input  logic               bk_load,
	input  logic               bk_save,
	input  logic               sd_ack,
	input  buf_addr_t          sd_buff_addr,
	input  logic               sd_buff_wr,
	input  logic [15:0]        sd_buff_dout,
	input  logic [15:0]        mem_dout,
	input  logic               mem_ready,
	output logic               cart_download,
	output logic               flash_1m,
	output logic [26:0]        last_addr,
	output logic [BIOS_AW-1:0] bios_wraddr,
	output logic [31:0]        bios_wrdata,
	output logic               bios_wr,
	output logic               bk_ena,
	output logic               bk_pending,
	output logic               bk_busy,
	output logic               bk_loading,
	output logic [31:0]        sd_lba,
	output logic               sd_rd,
	output logic               sd_wr,
	output logic [15:0]        sd_buff_din,
	output logic [15:0]        mem_addr,
	output logic [15:0]        mem_din,
	output logic               mem_req,
	output logic               mem_rnw
);

	logic      bios_download, cart_start;
	blk_t      save_sz;
	logic      xfer_start, xfer_done, buf_we;
	buf_addr_t buf_addr;

	// Memory halfword address, block then offset
	assign mem_addr = {sd_lba[7:0], buf_addr};

	// ========== download side ==========
	cart_download_monitor u_monitor (
		.clk_sys, .rst_n, .ioctl_download, .ioctl_index, .ioctl_addr, .ioctl_dout,
		.ioctl_wr, .bios_download, .cart_download, .cart_start, .last_addr, .flash_1m
	);

	bios_word_packer #(.BIOS_AW(BIOS_AW)) u_packer (
		.clk_sys, .rst_n, .bios_download, .ioctl_wr, .ioctl_addr, .ioctl_dout,
		.bios_wraddr, .bios_wrdata, .bios_wr
	);

	// ========== backup side ==========
	save_size_tracker u_tracker (
		.clk_sys, .rst_n, .cart_start, .flash_1m, .save_eeprom, .save_sram, .save_flash,
		.bus_req, .img_mounted, .img_readonly, .img_size, .bk_busy,
		.save_sz, .bk_ena, .bk_pending
	);

	backup_sequencer #(.MAX_LOAD_BLOCKS(MAX_LOAD_BLOCKS)) u_seq (
		.clk_sys, .rst_n, .bk_load, .bk_save, .bk_ena, .bk_pending, .save_sz,
		.img_mounted, .cart_download, .sd_ack, .xfer_done,
		.sd_lba, .sd_rd, .sd_wr, .xfer_start, .bk_busy, .bk_loading
	);

	block_transfer u_xfer (
		.clk_sys, .rst_n, .xfer_start, .mem_ready, .bk_loading,
		.buf_addr, .mem_req, .mem_rnw, .buf_we, .xfer_done
	);

	backup_buffer u_buf (
		.clk_sys, .buf_addr, .buf_we, .mem_dout, .sd_buff_addr, .sd_buff_wr,
		.sd_buff_dout, .mem_din, .sd_buff_din
	);

endmodule

// File: backup_buffer.sv
// ==============================
// Sector buffer
// 256 x 16 dual-port memory, port A on the
// memory side and port B on the SD side
// ==============================
`timescale 1ns/1ns

module backup_buffer
	import gba_pkg::*;
(
	input  logic        clk_sys,
	input  buf_addr_t   buf_addr,
	input  logic        buf_we,
	input  logic [15:0] mem_dout,
	input  buf_addr_t   sd_buff_addr,
	input  logic        sd_buff_wr,
	input  logic [15:0] sd_buff_dout,
	output logic [15:0] mem_din,
	output logic [15:0] sd_buff_din
);

	logic [15:0] ram [0:(2**BUF_AW)-1];

	// Both ports on the same clock edge
	always_ff @(posedge clk_sys) begin
		if (buf_we) ram[buf_addr] <= mem_dout;             // Port A from memory
		if (sd_buff_wr) ram[sd_buff_addr] <= sd_buff_dout; // Port B from SD
		mem_din     <= ram[buf_addr];                      // Registered reads
		sd_buff_din <= ram[sd_buff_addr];
	end

endmodule

// File: block_transfer.sv
// ==============================
// Block transfer engine
// One memory request per buffer halfword
// ==============================
`timescale 1ns/1ns

module block_transfer
	import gba_pkg::*;
(
	input  logic      clk_sys,
	input  logic      rst_n,
	input  logic      xfer_start,
	input  logic      mem_ready,
	input  logic      bk_loading,
	output buf_addr_t buf_addr,
	output logic      mem_req,
	output logic      mem_rnw,
	output logic      buf_we,
	output logic      xfer_done
);

	xfer_state_e state;

	assign mem_rnw = ~bk_loading;                                // Save reads memory
	assign buf_we  = ~bk_loading & mem_ready & (state == XF_WAIT); // Capture read data

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			state     <= XF_ISSUE;
			buf_addr  <= '0;
			mem_req   <= 1'b0;
			xfer_done <= 1'b0;
		end else begin
			mem_req <= 1'b0;
			if (!xfer_start) begin
				state     <= XF_ISSUE;
				buf_addr  <= '0;
				xfer_done <= 1'b0;
			end else if (!xfer_done) begin
				case (state)
					XF_ISSUE: begin
						mem_req <= 1'b1;  // Buffer read data valid this cycle
						state   <= XF_WAIT;
					end
					XF_WAIT: if (mem_ready) begin
						state <= XF_ISSUE;
						if (&buf_addr) xfer_done <= 1'b1; // Last halfword
						else           buf_addr  <= buf_addr + 1'b1;
					end
					default: state <= XF_ISSUE;
				endcase
			end
		end
	end

endmodule

// File: backup_sequencer.sv
// ==============================
// Backup load/save sequencer
// Load: SD read then buffer -> memory
// Save: memory -> buffer then SD write
// ==============================
`timescale 1ns/1ns

module backup_sequencer
	import gba_pkg::*;
#(
	parameter int MAX_LOAD_BLOCKS = 256 // Blocks read on every load
) (
	input  logic        clk_sys,
	input  logic        rst_n,
	input  logic        bk_load,
	input  logic        bk_save,
	input  logic        bk_ena,
	input  logic        bk_pending,
	input  blk_t        save_sz,
	input  logic        img_mounted,
	input  logic        cart_download,
	input  logic        sd_ack,
	input  logic        xfer_done,
	output logic [31:0] sd_lba,
	output logic        sd_rd,
	output logic        sd_wr,
	output logic        xfer_start,
	output logic        bk_busy,
	output logic        bk_loading
);

	localparam blk_t LAST_LOAD = blk_t'(MAX_LOAD_BLOCKS - 1);

	bk_phase_e phase;
	logic      old_load, old_save, old_ack;
	logic      ack_rise, ack_fall;
	logic      start_op;

	assign ack_rise = sd_ack & ~old_ack;
	assign ack_fall = old_ack & ~sd_ack;     // Sector done on SD side
	assign start_op = (bk_load & ~old_load & bk_ena) |
		(bk_save & ~old_save & bk_ena & bk_pending) |
		(cart_download & img_mounted);       // Image mounted with the cart

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			old_load   <= 1'b0;
			old_save   <= 1'b0;
			old_ack    <= 1'b0;
			phase      <= PH_START;
			sd_lba     <= '0;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
			xfer_start <= 1'b0;
			bk_busy    <= 1'b0;
			bk_loading <= 1'b0;
		end else begin
			old_load <= bk_load;
			old_save <= bk_save;
			old_ack  <= sd_ack;

			// SD request held until acknowledged
			if (ack_rise) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end

			if (!bk_busy) begin
				phase      <= PH_START;
				sd_lba     <= '0;
				xfer_start <= 1'b0;
				bk_loading <= 1'b0;
				if (start_op) begin
					bk_busy    <= 1'b1;
					bk_loading <= bk_load | img_mounted;
				end
			end else if (bk_loading) begin
				// ========== load ==========
				case (phase)
					PH_START: begin
						sd_rd <= 1'b1;
						phase <= PH_WAIT;
					end
					PH_WAIT: if (ack_fall) begin
						xfer_start <= 1'b1;  // Sector now in buffer
						phase      <= PH_FINISH;
					end
					PH_FINISH: if (xfer_done) begin
						xfer_start <= 1'b0;
						phase      <= PH_START;
						sd_lba     <= sd_lba + 32'd1;
						if (sd_lba[7:0] == LAST_LOAD) bk_busy <= 1'b0;
					end
					default: phase <= PH_START;
				endcase
			end else begin
				// ========== save ==========
				case (phase)
					PH_START: begin
						xfer_start <= 1'b1;
						phase      <= PH_WAIT;
					end
					PH_WAIT: if (xfer_done) begin
						xfer_start <= 1'b0;
						sd_wr      <= 1'b1;  // Buffer full, push to SD
						phase      <= PH_FINISH;
					end
					PH_FINISH: if (ack_fall) begin
						phase  <= PH_START;
						sd_lba <= sd_lba + 32'd1;
						if (sd_lba[7:0] == save_sz) bk_busy <= 1'b0;
					end
					default: phase <= PH_START;
				endcase
			end
		end
	end

endmodule

// File: save_size_tracker.sv
// ==============================
// Save size tracker
// Save length from observed save types or a
// mounted image, plus the dirty flag
// ==============================
`timescale 1ns/1ns

module save_size_tracker
	import gba_pkg::*;
(
	input  logic        clk_sys,
	input  logic        rst_n,
	input  logic        cart_start,
	input  logic        flash_1m,
	input  logic        save_eeprom,
	input  logic        save_sram,
	input  logic        save_flash,
	input  logic        bus_req,
	input  logic        img_mounted,
	input  logic        img_readonly,
	input  logic [31:0] img_size,
	input  logic        bk_busy,
	output blk_t        save_sz,
	output logic        bk_ena,
	output logic        bk_pending
);

	logic use_img;        // Size fixed by a mounted image
	logic save_write;
	logic img_take;
	blk_t type_mask;

	assign save_write = bus_req & (save_eeprom | save_sram | save_flash);
	assign img_take   = img_mounted & (img_size != 32'd0) & ~img_readonly;

	// Union of masks for every save type active on this access
	assign type_mask = (save_eeprom ? SZ_EEPROM : '0) |
		(save_sram ? SZ_SRAM : '0) |
		(save_flash ? {flash_1m, SZ_FLASH[6:0]} : '0);

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			use_img    <= 1'b0;
			save_sz    <= '0;
			bk_ena     <= 1'b0;
			bk_pending <= 1'b0;
		end else begin
			if (cart_start) begin
				use_img <= 1'b0;
				save_sz <= '0;
			end else if (img_take) begin
				use_img <= 1'b1;
				save_sz <= img_size[16:9] - 8'd1; // 512-byte blocks, minus one
			end else if (bus_req & ~use_img) begin
				save_sz <= save_sz | type_mask;
			end

			bk_ena <= |save_sz;

			// Dirty flag
			if (save_write)   bk_pending <= 1'b1;
			else if (bk_busy) bk_pending <= 1'b0;
		end
	end

endmodule

// File: bios_word_packer.sv
// ==============================
// BIOS word packer
// Joins halfword downloads into 32-bit
// BIOS write strobes
// ==============================
`timescale 1ns/1ns

module bios_word_packer #(
	parameter int BIOS_AW = 12 // BIOS word address width
) (
	input  logic               clk_sys,
	input  logic               rst_n,
	input  logic               bios_download,
	input  logic               ioctl_wr,
	input  logic [26:0]        ioctl_addr,
	input  logic [15:0]        ioctl_dout,
	output logic [BIOS_AW-1:0] bios_wraddr,
	output logic [31:0]        bios_wrdata,
	output logic               bios_wr
);

	logic take;
	assign take = bios_download & ioctl_wr;

	// Strobe on upper halfword only
	always_ff @(posedge clk_sys) begin
		if (!rst_n)
			bios_wr <= 1'b0;
		else
			bios_wr <= take & ioctl_addr[1];
	end

	always_ff @(posedge clk_sys) begin
		if (take) begin
			if (!ioctl_addr[1]) begin
				bios_wrdata[15:0] <= ioctl_dout; // Low half waits for its pair
			end else begin
				bios_wrdata[31:16] <= ioctl_dout;
				bios_wraddr        <= ioctl_addr[BIOS_AW+1:2]; // Byte to word address
			end
		end
	end

endmodule

// File: cart_download_monitor.sv
// ==============================
// Cartridge download monitor
// Sorts downloads into BIOS / cartridge,
// captures last address, finds flash marker
// ==============================
`timescale 1ns/1ns

module cart_download_monitor
	import gba_pkg::*;
(
	input  logic        clk_sys,
	input  logic        rst_n,
	input  logic        ioctl_download,
	input  logic [7:0]  ioctl_index,
	input  logic [26:0] ioctl_addr,
	input  logic [15:0] ioctl_dout,
	input  logic        ioctl_wr,
	output logic        bios_download,
	output logic        cart_download,
	output logic        cart_start,    // One cycle at start of cart stream
	output logic [26:0] last_addr,
	output logic        flash_1m
);

	logic        old_cart;          // Delayed cart_download for edges
	logic        cart_end;
	logic [63:0] hist_lo;           // Bytes taken low byte first
	logic [63:0] hist_hi;           // Bytes taken high byte first
	logic        sig_hit;
	logic [7:0]  b_lo, b_hi;

	assign b_lo       = ioctl_dout[7:0];
	assign b_hi       = ioctl_dout[15:8];
	assign cart_start = cart_download & ~old_cart;
	assign cart_end   = old_cart & ~cart_download;

	// Marker may end on either byte of the halfword, in either byte order
	assign sig_hit = ({hist_lo, b_lo} == FLASH_SIG) |
		({hist_lo[55:0], b_lo, b_hi} == FLASH_SIG) |
		({hist_hi, b_hi} == FLASH_SIG) |
		({hist_hi[55:0], b_hi, b_lo} == FLASH_SIG);

	// ==============================
	// Download class and flash flag
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			bios_download <= 1'b0;
			cart_download <= 1'b0;
			old_cart      <= 1'b0;
			flash_1m      <= 1'b0;
		end else begin
			bios_download <= ioctl_download & (ioctl_index == 8'd0);
			cart_download <= ioctl_download & |ioctl_index & ~&ioctl_index; // 1..254
			old_cart      <= cart_download;
			if (cart_start)
				flash_1m <= 1'b0;
			else if (cart_download & ioctl_wr & sig_hit)
				flash_1m <= 1'b1;
		end
	end

	// Byte history and end address, payload only
	always_ff @(posedge clk_sys) begin
		if (cart_download & ioctl_wr) begin
			hist_lo <= {hist_lo[47:0], b_lo, b_hi};
			hist_hi <= {hist_hi[47:0], b_hi, b_lo};
		end
		if (cart_end) last_addr <= ioctl_addr; // Address still holds final write
	end

endmodule

// File: gba_pkg.sv
// ==============================
// GBA backup shared definitions
// Sector buffer sizing, save-size masks,
// flash signature and FSM state encodings
// ==============================
package gba_pkg;

	// Sector buffer, one SD block of 256 halfwords
	localparam int BUF_AW = 8;
	typedef logic [BUF_AW-1:0] buf_addr_t;

	// Block index / save-size count
	typedef logic [7:0] blk_t;

	// 1-Mbit flash marker embedded in the cartridge image
	localparam logic [71:0] FLASH_SIG = "FLASH1M_V";

	// Save-size OR masks, in 512-byte blocks minus one
	localparam blk_t SZ_EEPROM = 8'h0F; // 8 KB
	localparam blk_t SZ_SRAM   = 8'h3F; // 32 KB
	localparam blk_t SZ_FLASH  = 8'h7F; // 64 KB, bit 7 added for 1-Mbit parts

	// Backup sequencer step
	typedef enum logic [1:0] {PH_START, PH_WAIT, PH_FINISH} bk_phase_e;

	// Block transfer state
	typedef enum logic {XF_ISSUE, XF_WAIT} xfer_state_e;

endpackage
